/* common/core_pkg.sv */
/*
 * core control package
 * settings register map, field types and readback constants
 */
package core_pkg;

    //////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////
    localparam int SET_ADDR_W = 8;
    localparam int SET_DATA_W = 32;
    localparam int RB_W       = 64;
    localparam int SEN_W      = 8;
    localparam int SPI_DIV_W  = 16;

    //////////////////////////////////////////////////
    // settings addresses
    //////////////////////////////////////////////////
    localparam logic [SET_ADDR_W-1:0] SR_SPI       = 8'd8;
    localparam logic [SET_ADDR_W-1:0] SPI_DIV_OFS  = 8'd0;
    localparam logic [SET_ADDR_W-1:0] SPI_CFG_OFS  = 8'd1;
    // a write here starts a transfer
    localparam logic [SET_ADDR_W-1:0] SPI_DATA_OFS = 8'd2;
    localparam logic [SET_ADDR_W-1:0] SR_MISC      = 8'd16;
    localparam logic [SET_ADDR_W-1:0] SR_READBACK  = 8'd32;
    localparam logic [SET_ADDR_W-1:0] SR_GPSDO_ST  = 8'd40;
    localparam logic [SET_ADDR_W-1:0] SR_SYNC      = 8'd48;

    // readback constants
    localparam logic [31:0] RB_SIGNATURE = 32'hACE0BA5E;
    localparam logic [15:0] COMPAT_MAJOR = 16'h000E;
    localparam logic [15:0] COMPAT_MINOR = 16'h0000;
    localparam logic [7:0]  RADIO_STATUS = 8'h01;

    typedef enum logic [1:0] {
        RB_COMPAT = 2'd0,
        RB_SPI    = 2'd1,
        RB_STATUS = 2'd2,
        RB_LOCK   = 2'd3
    } rb_sel_t;

    typedef enum logic [1:0] {
        PPS_GPSDO = 2'd0,
        PPS_EXT   = 2'd1,
        PPS_INT   = 2'd2,
        PPS_OFF   = 2'd3
    } pps_sel_t;

    // num_bits of 0 means a full 32 bit transfer
    typedef struct packed {
        logic [5:0]       num_bits;
        logic [SEN_W-1:0] slave_sel;
    } spi_cfg_t;

    localparam logic [SEN_W-1:0] SPI_IDLE_SEN = 8'hFF;

endpackage

/* common/set_bus_if.sv */
/*
 * settings bus
 * strobe, address and data to the registers, plus the SPI ready level
 */
`timescale 1ns/100ps

interface set_bus_if;

    logic                            set_stb;
    logic [core_pkg::SET_ADDR_W-1:0] set_addr;
    logic [core_pkg::SET_DATA_W-1:0] set_data;
    // high while the SPI master can take a new data word
    logic                            ready;

    modport regs (
        input set_stb,
        input set_addr,
        input set_data
    );

    modport spi (
        input  set_stb,
        input  set_addr,
        input  set_data,
        output ready
    );

endinterface

/* spi/spi_clk_divider.sv */
/*
 * SPI clock divider
 * one cycle tick every divider+1 cycles, sclk half period
 */
`timescale 1ns/100ps

module spi_clk_divider (
    input  logic                           radio_clk,
    input  logic                           bus_rst,
    input  logic                           i_en,
    input  logic [core_pkg::SPI_DIV_W-1:0] i_divider,
    output logic                           o_tick
);

    logic [core_pkg::SPI_DIV_W-1:0] cnt;

    assign o_tick = i_en && (cnt == '0);

    // parked at the reload value while disabled,
    // so the first tick lands a full half period after enable
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            cnt <= '0;
        end else if (!i_en) begin
            cnt <= i_divider;
        end else if (cnt == '0) begin
            cnt <= i_divider;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

/* spi/spi_shift_reg.sv */
/*
 * SPI shift data path
 * MSB first MOSI shifter and MISO capture into the readback word
 */
`timescale 1ns/100ps

module spi_shift_reg (
    input  logic        radio_clk,
    input  logic        bus_rst,
    input  logic        i_load,
    input  logic [31:0] i_data,
    input  logic        i_shift,
    input  logic        i_sample,
    input  logic        i_miso,
    output logic        o_mosi,
    output logic [31:0] o_readback
);

    logic [31:0] tx_word;

    // bit 31 is on the pin from load onwards
    assign o_mosi = tx_word[31];

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            tx_word <= '0;
        end else if (i_load) begin
            tx_word <= i_data;
        end else if (i_shift) begin
            tx_word <= {tx_word[30:0], 1'b0};
        end
    end

    // received bits end up right aligned
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_readback <= '0;
        end else if (i_load) begin
            o_readback <= '0;
        end else if (i_sample) begin
            o_readback <= {o_readback[30:0], i_miso};
        end
    end

endmodule

/* spi/spi_shift_fsm.sv */
/*
 * SPI transfer control
 * holds divider and config, sequences sclk edges, chip enables and ready
 */
`timescale 1ns/100ps

module spi_shift_fsm (
    input  logic                           radio_clk,
    input  logic                           bus_rst,
    set_bus_if.spi                         set_bus,
    input  logic                           i_tick,
    output logic                           o_div_en,
    output logic [core_pkg::SPI_DIV_W-1:0] o_divider,
    output logic                           o_load,
    output logic                           o_shift,
    output logic                           o_sample,
    output logic [core_pkg::SEN_W-1:0]     o_sen,
    output logic                           o_sclk
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LEAD,
        ST_CLOCKING,
        ST_TRAIL
    } state_t;

    state_t             state;
    core_pkg::spi_cfg_t cfg;
    logic [5:0]         xfer_bits;
    logic [5:0]         bit_cnt;
    logic               ready_q;
    logic               div_wr;
    logic               cfg_wr;
    logic               start;

    assign div_wr = set_bus.set_stb &&
                    (set_bus.set_addr == core_pkg::SR_SPI + core_pkg::SPI_DIV_OFS);
    assign cfg_wr = set_bus.set_stb &&
                    (set_bus.set_addr == core_pkg::SR_SPI + core_pkg::SPI_CFG_OFS);
    // data writes only count while idle
    assign start  = set_bus.set_stb && (state == ST_IDLE) &&
                    (set_bus.set_addr == core_pkg::SR_SPI + core_pkg::SPI_DATA_OFS);

    assign o_load        = start;
    assign o_div_en      = (state != ST_IDLE);
    // rising sclk samples, falling sclk shifts
    assign o_sample      = i_tick && ((state == ST_LEAD) || (state == ST_CLOCKING && !o_sclk));
    assign o_shift       = i_tick && (state == ST_CLOCKING) && o_sclk;
    assign set_bus.ready = ready_q;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_divider <= '0;
            cfg       <= '0;
        end else begin
            if (div_wr) begin
                o_divider <= set_bus.set_data[core_pkg::SPI_DIV_W-1:0];
            end
            if (cfg_wr) begin
                cfg <= core_pkg::spi_cfg_t'(set_bus.set_data[13:0]);
            end
        end
    end

    //////////////////////////////////////////////////
    // transfer sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            state     <= ST_IDLE;
            ready_q   <= 1'b1;
            o_sen     <= core_pkg::SPI_IDLE_SEN;
            o_sclk    <= 1'b0;
            bit_cnt   <= '0;
            xfer_bits <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_LEAD;
                        ready_q   <= 1'b0;
                        o_sen     <= ~cfg.slave_sel;
                        bit_cnt   <= '0;
                        xfer_bits <= (cfg.num_bits == '0) ? 6'd32 : cfg.num_bits;
                    end
                end
                ST_LEAD: begin
                    // half period of setup before the first rising edge
                    if (i_tick) begin
                        state  <= ST_CLOCKING;
                        o_sclk <= 1'b1;
                    end
                end
                ST_CLOCKING: begin
                    if (i_tick) begin
                        o_sclk <= ~o_sclk;
                        if (o_sclk) begin
                            bit_cnt <= bit_cnt + 6'd1;
                            if (bit_cnt + 6'd1 == xfer_bits) begin
                                state <= ST_TRAIL;
                            end
                        end
                    end
                end
                default: begin
                    if (i_tick) begin
                        state   <= ST_IDLE;
                        ready_q <= 1'b1;
                        o_sen   <= core_pkg::SPI_IDLE_SEN;
                    end
                end
            endcase
        end
    end

endmodule

/* design/pps_tick_timer.sv */
/*
 * internal PPS timer
 * one cycle pulse every PPS_PERIOD clock cycles
 */
`timescale 1ns/100ps

module pps_tick_timer #(
    parameter int PPS_PERIOD = 100000000
) (
    input  logic radio_clk,
    input  logic bus_rst,
    output logic o_pps_tick
);

    localparam int               CNT_W = $clog2(PPS_PERIOD);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(PPS_PERIOD - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            cnt        <= '0;
            o_pps_tick <= 1'b0;
        end else begin
            o_pps_tick <= (cnt == LAST);
            if (cnt == LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* design/pps_source_mux.sv */
/*
 * PPS source select
 * two flop synchronizers on GPSDO, external and internal PPS, then a mux
 */
`timescale 1ns/100ps

module pps_source_mux (
    input  logic               radio_clk,
    input  logic               i_pps_int,
    input  logic               i_pps_ext,
    input  logic               i_pps_tick,
    input  core_pkg::pps_sel_t i_pps_sel,
    output logic               o_pps
);

    // bit 0 GPSDO (board pps_int pin), bit 1 external, bit 2 timer
    logic [2:0] pps_meta;
    logic [2:0] pps_sync;

    always_ff @(posedge radio_clk) begin
        pps_meta <= {i_pps_tick, i_pps_ext, i_pps_int};
        pps_sync <= pps_meta;
    end

    always_comb begin
        case (i_pps_sel)
            core_pkg::PPS_GPSDO: o_pps = pps_sync[0];
            core_pkg::PPS_EXT:   o_pps = pps_sync[1];
            core_pkg::PPS_INT:   o_pps = pps_sync[2];
            core_pkg::PPS_OFF:   o_pps = 1'b0;
            default:             o_pps = 1'b0;
        endcase
    end

endmodule

/* design/core_regs.sv */
/*
 * core settings registers
 * misc, readback select, GPSDO status and sync registers plus the readback mux
 */
`timescale 1ns/100ps

module core_regs (
    input  logic                      radio_clk,
    input  logic                      bus_rst,
    set_bus_if.regs                   set_bus,
    input  logic [31:0]               i_spi_readback,
    input  logic [31:0]               i_rb_misc,
    input  logic [1:0]                i_lock_signals,
    output logic [31:0]               o_misc_outs,
    output core_pkg::pps_sel_t        o_pps_sel,
    output logic                      o_time_sync,
    output logic [core_pkg::RB_W-1:0] o_readback
);

    core_pkg::rb_sel_t rb_sel;
    logic [7:0]        gpsdo_st;
    logic [1:0]        lock_meta;
    logic [1:0]        lock_sync;

    //////////////////////////////////////////////////
    // setting registers
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_misc_outs <= '0;
            rb_sel      <= core_pkg::RB_COMPAT;
            o_pps_sel   <= core_pkg::PPS_GPSDO;
            o_time_sync <= 1'b0;
        end else if (set_bus.set_stb) begin
            case (set_bus.set_addr)
                core_pkg::SR_MISC: begin
                    o_misc_outs <= set_bus.set_data;
                end
                core_pkg::SR_READBACK: begin
                    rb_sel <= core_pkg::rb_sel_t'(set_bus.set_data[1:0]);
                end
                core_pkg::SR_SYNC: begin
                    o_pps_sel   <= core_pkg::pps_sel_t'(set_bus.set_data[1:0]);
                    o_time_sync <= set_bus.set_data[2];
                end
                default: begin
                end
            endcase
        end
    end

    // GPSDO status survives a core reset
    always_ff @(posedge radio_clk) begin
        if (set_bus.set_stb && set_bus.set_addr == core_pkg::SR_GPSDO_ST) begin
            gpsdo_st <= set_bus.set_data[7:0];
        end
    end

    // front end lock inputs are asynchronous
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
        end else begin
            lock_meta <= i_lock_signals;
            lock_sync <= lock_meta;
        end
    end

    //////////////////////////////////////////////////
    // readback word
    //////////////////////////////////////////////////
    always_comb begin
        case (rb_sel)
            core_pkg::RB_COMPAT: begin
                o_readback = {core_pkg::RB_SIGNATURE, core_pkg::COMPAT_MAJOR,
                              core_pkg::COMPAT_MINOR};
            end
            core_pkg::RB_SPI: begin
                o_readback = {32'h0, i_spi_readback};
            end
            core_pkg::RB_STATUS: begin
                o_readback = {16'h0, core_pkg::RADIO_STATUS, gpsdo_st, i_rb_misc};
            end
            default: begin
                o_readback = {62'h0, lock_sync};
            end
        endcase
    end

endmodule

/* design/core_ctrl_top.sv */
/*
 * core control plane top
 * settings bus, readback, PPS selection and SPI master on radio_clk
 */
`timescale 1ns/100ps

module core_ctrl_top #(
    parameter int PPS_PERIOD = 100000000
) (
    input  logic                            radio_clk,
    input  logic                            bus_rst,
    // settings bus
    input  logic                            i_set_stb,
    input  logic [core_pkg::SET_ADDR_W-1:0] i_set_addr,
    input  logic [core_pkg::SET_DATA_W-1:0] i_set_data,
    // readback and status
    output logic                            o_ready,
    output logic [core_pkg::RB_W-1:0]       o_readback,
    input  logic [31:0]                     i_rb_misc,
    output logic [31:0]                     o_misc_outs,
    input  logic [1:0]                      i_lock_signals,
    // timing
    input  logic                            i_pps_int,
    input  logic                            i_pps_ext,
    output logic                            o_pps,
    output logic                            o_time_sync,
    // SPI pins
    output logic [core_pkg::SEN_W-1:0]      o_sen,
    output logic                            o_sclk,
    output logic                            o_mosi,
    input  logic                            i_miso
);

    set_bus_if set_bus ();

    logic [31:0]                    spi_readback;
    core_pkg::pps_sel_t             pps_sel;
    logic                           pps_tick;
    logic                           div_en;
    logic                           div_tick;
    logic [core_pkg::SPI_DIV_W-1:0] divider;
    logic                           spi_load;
    logic                           spi_shift;
    logic                           spi_sample;

    assign set_bus.set_stb  = i_set_stb;
    assign set_bus.set_addr = i_set_addr;
    assign set_bus.set_data = i_set_data;
    assign o_ready          = set_bus.ready;

    core_regs u_core_regs (
        .radio_clk(radio_clk), .bus_rst(bus_rst), .set_bus(set_bus.regs),
        .i_spi_readback(spi_readback), .i_rb_misc(i_rb_misc),
        .i_lock_signals(i_lock_signals), .o_misc_outs(o_misc_outs),
        .o_pps_sel(pps_sel), .o_time_sync(o_time_sync), .o_readback(o_readback)
    );

    //////////////////////////////////////////////////
    // PPS
    //////////////////////////////////////////////////
    pps_tick_timer #(.PPS_PERIOD(PPS_PERIOD)) u_pps_timer (
        .radio_clk(radio_clk), .bus_rst(bus_rst), .o_pps_tick(pps_tick)
    );

    pps_source_mux u_pps_mux (
        .radio_clk(radio_clk), .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext),
        .i_pps_tick(pps_tick), .i_pps_sel(pps_sel), .o_pps(o_pps)
    );

    //////////////////////////////////////////////////
    // SPI master
    //////////////////////////////////////////////////
    spi_shift_fsm u_spi_fsm (
        .radio_clk(radio_clk), .bus_rst(bus_rst), .set_bus(set_bus.spi),
        .i_tick(div_tick), .o_div_en(div_en), .o_divider(divider),
        .o_load(spi_load), .o_shift(spi_shift), .o_sample(spi_sample),
        .o_sen(o_sen), .o_sclk(o_sclk)
    );

    spi_clk_divider u_spi_div (
        .radio_clk(radio_clk), .bus_rst(bus_rst), .i_en(div_en),
        .i_divider(divider), .o_tick(div_tick)
    );

    spi_shift_reg u_spi_shift (
        .radio_clk(radio_clk), .bus_rst(bus_rst), .i_load(spi_load),
        .i_data(i_set_data), .i_shift(spi_shift), .i_sample(spi_sample),
        .i_miso(i_miso), .o_mosi(o_mosi), .o_readback(spi_readback)
    );

endmodule

/* tb/core_ctrl_sva.sv */
/*
 * control plane assertions
 * a small model of the settings map and checks on the top level ports
 */
`timescale 1ns/100ps

module core_ctrl_sva #(
    parameter int PPS_PERIOD = 100000000
) (
    input logic        radio_clk,
    input logic        bus_rst,
    input logic        i_set_stb,
    input logic [7:0]  i_set_addr,
    input logic [31:0] i_set_data,
    input logic [31:0] i_rb_misc,
    input logic [1:0]  i_lock_signals,
    input logic        i_pps_int,
    input logic        i_pps_ext,
    input logic        o_ready,
    input logic [63:0] o_readback,
    input logic [31:0] o_misc_outs,
    input logic        o_pps,
    input logic        o_time_sync,
    input logic [7:0]  o_sen,
    input logic        o_sclk,
    input logic        o_mosi
);

    localparam logic [7:0] SPI_CFG_ADDR  = core_pkg::SR_SPI + core_pkg::SPI_CFG_OFS;
    localparam logic [7:0] SPI_DATA_ADDR = core_pkg::SR_SPI + core_pkg::SPI_DATA_OFS;

    logic [31:0] m_misc;
    logic [1:0]  m_rb_sel;
    logic [2:0]  m_sync;
    logic [13:0] m_cfg;
    logic [7:0]  m_sen;
    logic [31:0] m_spi;
    int          m_bits;
    logic [7:0]  m_gpsdo;
    logic        m_gpsdo_ok = 1'b0;
    logic [1:0]  lock_d1;
    logic [1:0]  lock_d2;
    logic [1:0]  gps_d;
    logic [1:0]  ext_d;
    logic        pps_q;
    logic        int_seen;
    int          int_gap;
    logic        sclk_q;
    int          sclk_rises;
    logic        data_wr;
    logic [63:0] rb_exp;
    logic        pps_exp;
    int          fail_cnt = 0;

    // top n received bits of an MSB first word, right aligned
    function automatic logic [31:0] top_bits(input logic [31:0] w, input logic [5:0] n);
        if (n == 6'd0) begin
            return w;
        end
        return w >> (6'd32 - n);
    endfunction

    // a data write only starts a transfer while the master is ready
    assign data_wr = i_set_stb && (i_set_addr == SPI_DATA_ADDR) && o_ready;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            m_misc   <= '0;
            m_rb_sel <= '0;
            m_sync   <= '0;
            m_cfg    <= '0;
            m_sen    <= 8'hFF;
            m_spi    <= '0;
            m_bits   <= 0;
            lock_d1  <= '0;
            lock_d2  <= '0;
        end else begin
            lock_d1 <= i_lock_signals;
            lock_d2 <= lock_d1;
            if (i_set_stb) begin
                case (i_set_addr)
                    core_pkg::SR_MISC:     m_misc   <= i_set_data;
                    core_pkg::SR_READBACK: m_rb_sel <= i_set_data[1:0];
                    core_pkg::SR_SYNC:     m_sync   <= i_set_data[2:0];
                    SPI_CFG_ADDR:          m_cfg    <= i_set_data[13:0];
                    default: begin
                    end
                endcase
            end
            if (data_wr) begin
                m_sen  <= ~m_cfg[7:0];
                m_spi  <= top_bits(i_set_data, m_cfg[13:8]);
                m_bits <= (m_cfg[13:8] == 6'd0) ? 32 : m_cfg[13:8];
            end
        end
    end

    // status and pps delay lines have no reset
    always_ff @(posedge radio_clk) begin
        gps_d <= {gps_d[0], i_pps_int};
        ext_d <= {ext_d[0], i_pps_ext};
        if (i_set_stb && i_set_addr == core_pkg::SR_GPSDO_ST) begin
            m_gpsdo    <= i_set_data[7:0];
            m_gpsdo_ok <= 1'b1;
        end
    end

    // cycles between rising edges of the internal pps
    always_ff @(posedge radio_clk) begin
        pps_q <= o_pps;
        if (bus_rst || m_sync[1:0] != core_pkg::PPS_INT) begin
            int_seen <= 1'b0;
            int_gap  <= 0;
        end else if (o_pps && !pps_q) begin
            int_seen <= 1'b1;
            int_gap  <= 1;
        end else begin
            int_gap <= int_gap + 1;
        end
    end

    // sclk rising edges within the current transfer
    always_ff @(posedge radio_clk) begin
        sclk_q <= o_sclk;
        if (bus_rst || data_wr) begin
            sclk_rises <= 0;
        end else if (o_sclk && !sclk_q) begin
            sclk_rises <= sclk_rises + 1;
        end
    end

    always_comb begin
        case (m_rb_sel)
            core_pkg::RB_COMPAT: rb_exp = {32'hACE0BA5E, 16'h000E, 16'h0000};
            core_pkg::RB_SPI:    rb_exp = {32'h0, m_spi};
            core_pkg::RB_STATUS: rb_exp = {16'h0, 8'h01, m_gpsdo, i_rb_misc};
            default:             rb_exp = {62'h0, lock_d2};
        endcase
        case (m_sync[1:0])
            core_pkg::PPS_GPSDO: pps_exp = gps_d[1];
            core_pkg::PPS_EXT:   pps_exp = ext_d[1];
            default:             pps_exp = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    reset_values: assert property (@(posedge radio_clk)
        $fell(bus_rst) |-> o_ready && o_sen == 8'hFF && !o_sclk && !o_mosi &&
                           o_misc_outs == 32'h0 && !o_time_sync)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("reset: outputs not at their reset levels when reset ends");
        end

    misc_reg: assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_misc_outs == m_misc)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("misc: expected %h actual %h", $sampled(m_misc), $sampled(o_misc_outs));
        end

    readback_map: assert property (@(posedge radio_clk) disable iff (bus_rst)
        m_rb_sel != core_pkg::RB_SPI && (m_rb_sel != core_pkg::RB_STATUS || m_gpsdo_ok)
        |-> o_readback == rb_exp)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("readback: expected %h actual %h", $sampled(rb_exp), $sampled(o_readback));
        end

    pps_select: assert property (@(posedge radio_clk) disable iff (bus_rst)
        m_sync[1:0] != core_pkg::PPS_INT |-> o_pps == pps_exp)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("pps: expected %b actual %b", $sampled(pps_exp), $sampled(o_pps));
        end

    pps_period: assert property (@(posedge radio_clk) disable iff (bus_rst)
        m_sync[1:0] == core_pkg::PPS_INT && o_pps && !pps_q && int_seen
        |-> int_gap == PPS_PERIOD)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("pps: expected period %0d actual %0d", PPS_PERIOD, $sampled(int_gap));
        end

    time_sync: assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_time_sync == m_sync[2])
        else begin
            fail_cnt = fail_cnt + 1;
            $error("pps: time sync expected %b actual %b", $sampled(m_sync[2]),
                   $sampled(o_time_sync));
        end

    spi_idle_pins: assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_ready |-> o_sen == 8'hFF && !o_sclk)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("spi_idle: chip enables or sclk active while ready");
        end

    spi_busy_sen: assert property (@(posedge radio_clk) disable iff (bus_rst)
        !o_ready |-> o_sen == m_sen)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("spi_idle: sen expected %h actual %h", $sampled(m_sen), $sampled(o_sen));
        end

    spi_start: assert property (@(posedge radio_clk) disable iff (bus_rst)
        data_wr |=> !o_ready)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("spi_idle: ready did not fall after a data write");
        end

    spi_sclk_edges: assert property (@(posedge radio_clk) disable iff (bus_rst)
        $rose(o_ready) |-> sclk_rises == m_bits)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("spi_loopback: sclk rising edges expected %0d actual %0d",
                   $sampled(m_bits), $sampled(sclk_rises));
        end

    spi_result: assert property (@(posedge radio_clk) disable iff (bus_rst)
        m_rb_sel == core_pkg::RB_SPI && o_ready |-> o_readback == rb_exp)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("spi_loopback: expected %h actual %h", $sampled(m_spi),
                   $sampled(o_readback[31:0]));
        end

endmodule

bind core_ctrl_top core_ctrl_sva #(.PPS_PERIOD(PPS_PERIOD)) u_sva (
    .radio_clk(radio_clk), .bus_rst(bus_rst), .i_set_stb(i_set_stb),
    .i_set_addr(i_set_addr), .i_set_data(i_set_data), .i_rb_misc(i_rb_misc),
    .i_lock_signals(i_lock_signals), .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext),
    .o_ready(o_ready), .o_readback(o_readback), .o_misc_outs(o_misc_outs),
    .o_pps(o_pps), .o_time_sync(o_time_sync), .o_sen(o_sen), .o_sclk(o_sclk),
    .o_mosi(o_mosi)
);

/* tb/core_ctrl_tb.sv */
/*
 * core control plane testbench
 * drives the settings bus, PPS and lock inputs, loops MOSI back to MISO
 */
`timescale 1ns/100ps

module core_ctrl_tb;

    localparam int PPS_PERIOD = 50;
    localparam int WAIT_MAX   = 4000;

    logic        radio_clk = 1'b0;
    logic        bus_rst;
    logic        set_stb;
    logic [7:0]  set_addr;
    logic [31:0] set_data;
    logic [31:0] rb_misc;
    logic [1:0]  lock_signals;
    logic        pps_int;
    logic        pps_ext;
    logic        ready;
    logic [63:0] readback;
    logic [31:0] misc_outs;
    logic        pps;
    logic        time_sync;
    logic [7:0]  sen;
    logic        sclk;
    logic        mosi;
    int          seed = 32'hb4c9;
    int          n_pass = 0;
    int          n_fail = 0;
    int          test_errs = 0;
    int          fails_seen = 0;

    always #2 radio_clk = ~radio_clk;

    // MISO tied straight to MOSI
    core_ctrl_top #(.PPS_PERIOD(PPS_PERIOD)) u_dut (
        .radio_clk(radio_clk), .bus_rst(bus_rst), .i_set_stb(set_stb),
        .i_set_addr(set_addr), .i_set_data(set_data), .o_ready(ready),
        .o_readback(readback), .i_rb_misc(rb_misc), .o_misc_outs(misc_outs),
        .i_lock_signals(lock_signals), .i_pps_int(pps_int), .i_pps_ext(pps_ext),
        .o_pps(pps), .o_time_sync(time_sync), .o_sen(sen), .o_sclk(sclk),
        .o_mosi(mosi), .i_miso(mosi)
    );

    // inputs change half a ns after the rising edge
    task automatic step();
        @(posedge radio_clk);
        #0.5;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        set_stb  = 1'b1;
        set_addr = addr;
        set_data = data;
        step();
        set_stb  = 1'b0;
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (!ready && n < WAIT_MAX) begin
            step();
            n++;
        end
        if (!ready) begin
            $display("%s: o_ready still low after %0d cycles", name, WAIT_MAX);
            test_errs++;
        end
    endtask

    task automatic wait_pps_rise(input string name);
        int   n;
        logic last;
        n    = 0;
        last = 1'b1;
        while (!(pps && !last) && n < WAIT_MAX) begin
            last = pps;
            step();
            n++;
        end
        if (!(pps && !last)) begin
            $display("%s: no rising edge on o_pps within %0d cycles", name, WAIT_MAX);
            test_errs++;
        end
    endtask

    // assertion failures since the last test plus timeouts
    task automatic end_test(input string name);
        int fails;
        fails = u_dut.u_sva.fail_cnt - fails_seen + test_errs;
        if (fails == 0) begin
            n_pass++;
            $display("test %s passed", name);
        end else begin
            n_fail++;
            $display("test %s failed with %0d errors", name, fails);
        end
        fails_seen = u_dut.u_sva.fail_cnt;
        test_errs  = 0;
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic run_misc();
        write_reg(core_pkg::SR_MISC, $random(seed));
        write_reg(core_pkg::SR_READBACK, 32'(core_pkg::RB_COMPAT));
        write_reg(core_pkg::SR_SYNC, 32'h0);
        write_reg(core_pkg::SR_MISC, $random(seed));
        idle(2);
        end_test("misc");
    endtask

    task automatic run_readback();
        write_reg(core_pkg::SR_GPSDO_ST, $random(seed));
        write_reg(core_pkg::SR_READBACK, 32'(core_pkg::RB_COMPAT));
        idle(2);
        write_reg(core_pkg::SR_READBACK, 32'(core_pkg::RB_STATUS));
        repeat (6) begin
            rb_misc = $random(seed);
            step();
        end
        write_reg(core_pkg::SR_READBACK, 32'(core_pkg::RB_LOCK));
        repeat (8) begin
            lock_signals = 2'($random(seed));
            step();
        end
        write_reg(core_pkg::SR_READBACK, 32'(core_pkg::RB_COMPAT));
        idle(2);
        end_test("readback");
    endtask

    task automatic run_pps();
        write_reg(core_pkg::SR_SYNC, 32'(core_pkg::PPS_GPSDO));
        repeat (10) begin
            pps_int = 1'($random(seed));
            step();
        end
        write_reg(core_pkg::SR_SYNC, 32'(core_pkg::PPS_EXT));
        repeat (10) begin
            pps_ext = 1'($random(seed));
            step();
        end
        // internal timer with the time sync level raised
        write_reg(core_pkg::SR_SYNC, {29'h0, 1'b1, core_pkg::PPS_INT});
        repeat (3) wait_pps_rise("pps");
        write_reg(core_pkg::SR_SYNC, 32'(core_pkg::PPS_OFF));
        repeat (10) begin
            pps_int = 1'($random(seed));
            pps_ext = 1'($random(seed));
            step();
        end
        write_reg(core_pkg::SR_SYNC, 32'h0);
        pps_int = 1'b0;
        pps_ext = 1'b0;
        idle(2);
        end_test("pps");
    endtask

    task automatic run_spi_idle();
        write_reg(core_pkg::SR_SPI + core_pkg::SPI_DIV_OFS, 32'd1);
        write_reg(core_pkg::SR_SPI + core_pkg::SPI_CFG_OFS, {18'h0, 6'd8, 8'h04});
        write_reg(core_pkg::SR_SPI + core_pkg::SPI_DATA_OFS, $random(seed));
        wait_ready("spi_idle");
        idle(2);
        end_test("spi_idle");
    endtask

    task automatic run_spi_loopback();
        logic [5:0] bit_list [4] = '{6'd0, 6'd5, 6'd17, 6'd1};
        write_reg(core_pkg::SR_READBACK, 32'(core_pkg::RB_SPI));
        for (int i = 0; i < 4; i++) begin
            write_reg(core_pkg::SR_SPI + core_pkg::SPI_DIV_OFS, 32'(i));
            write_reg(core_pkg::SR_SPI + core_pkg::SPI_CFG_OFS,
                      {18'h0, bit_list[i], 8'($random(seed))});
            write_reg(core_pkg::SR_SPI + core_pkg::SPI_DATA_OFS, $random(seed));
            idle(2);
            // lands mid transfer and must be dropped
            write_reg(core_pkg::SR_SPI + core_pkg::SPI_DATA_OFS, $random(seed));
            wait_ready("spi_loopback");
            idle(3);
        end
        end_test("spi_loopback");
    endtask

    initial begin
        bus_rst      = 1'b1;
        set_stb      = 1'b0;
        set_addr     = '0;
        set_data     = '0;
        rb_misc      = '0;
        lock_signals = '0;
        pps_int      = 1'b0;
        pps_ext      = 1'b0;
        repeat (16) @(posedge radio_clk);
        #0.5;
        bus_rst = 1'b0;
        idle(2);

        run_misc();
        run_readback();
        run_pps();
        run_spi_idle();
        run_spi_loopback();

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sources.f */
common/core_pkg.sv
common/set_bus_if.sv
spi/spi_clk_divider.sv
spi/spi_shift_reg.sv
spi/spi_shift_fsm.sv
design/pps_tick_timer.sv
design/pps_source_mux.sv
design/core_regs.sv
design/core_ctrl_top.sv
tb/core_ctrl_sva.sv
tb/core_ctrl_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal
TOP       := core_ctrl_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := ** PASS **

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
